/* vlog.f */
+incdir+include
src/pma_pkg.sv
src/pma_region_regs.sv
src/pma_checker.sv
src/pma_unit_top.sv
test/pma_tb.sv

/* Makefile */
# Verilator build for the PMA unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only --timing
TOP       ?= pma_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
SIM_LOG   ?= sim.log
PASS_MSG  := TEST OK

SOURCES := $(shell grep -v '^+' $(FILELIST)) include/pma_tb_tasks.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	@grep -q "^$(PASS_MSG)$$" $(SIM_LOG) || (echo "simulation failed, see $(SIM_LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(SIM_LOG)

/* include/pma_tb_tasks.svh */
/*
 * Testbench helpers: reference model, compare tasks,
 * cycle driver, table writes and per-test bookkeeping
 */

`ifndef PMA_TB_TASKS_SVH
`define PMA_TB_TASKS_SVH

// Testbench copy of the region table
pma_cfg_t    model_tbl [PMA_NUM_REGIONS];
// Strobe of the last cycle, response due now
logic        pend_valid;
pma_resp_t   pend_resp;
logic [31:0] pend_addr;
// Expected state of the fault capture
logic        exp_fault_valid;
logic [31:0] exp_fault_addr;

function automatic pma_cfg_t make_cfg(input logic [31:0] lo, input logic [31:0] hi,
                                      input logic m, input logic b,
                                      input logic c, input logic i);
  return '{lo, hi, m, b, c, i};
endfunction

function automatic pma_trans_t make_trans(input logic [31:0] addr, input access_kind_e kind,
                                          input logic mis, input logic pp,
                                          input logic dbg);
  return '{addr, kind, mis, pp, dbg};
endfunction

// Expected response from the attribute rules
function automatic pma_resp_t predict_resp(input pma_trans_t t);
  pma_cfg_t    e;
  pma_resp_t   r;
  logic [31:0] wa;
  e  = PMA_R_DEFAULT;
  wa = t.addr >> 2;
  // Ascending scan, a later hit overrides so the top index wins
  for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
    if (wa >= model_tbl[i].word_addr_low && wa < model_tbl[i].word_addr_high) begin
      e = model_tbl[i];
    end
  end
  if (t.debug_mode && t.addr >= DM_REGION_START && t.addr < DM_REGION_END) begin
    e = PMA_DBG;
  end
  r.err        = !e.main && (t.kind == ACC_FETCH || t.misaligned || t.pushpop);
  r.integrity  = e.integrity;
  r.cacheable  = e.cacheable;
  r.bufferable = (t.kind == ACC_STORE) && e.bufferable;
  return r;
endfunction

task automatic check_resp(input pma_resp_t got, input pma_resp_t exp, input string msg);
  if (got !== exp) begin
    $display("mismatch at %0t: %s got %b expected %b (err,int,buf,cac)",
             $time, msg, got, exp);
    errors++;
  end
endtask

task automatic check_fault(input logic got_v, input logic [31:0] got_a,
                           input logic exp_v, input logic [31:0] exp_a);
  if (got_v !== exp_v || got_a !== exp_a) begin
    $display("mismatch at %0t: fault capture got %b/%h expected %b/%h",
             $time, got_v, got_a, exp_v, exp_a);
    errors++;
  end
endtask

// One clock cycle, entered and left 1 ns after the edge
task automatic run_cycle(input logic valid, input pma_trans_t t, input logic clr);
  if (pend_valid && !resp_valid_o) begin
    $display("error at %0t: no response one cycle after the strobe to %h",
             $time, pend_addr);
    errors++;
  end else if (pend_valid) begin
    check_resp(resp_o, pend_resp, $sformatf("response to %h", pend_addr));
  end else if (resp_valid_o) begin
    $display("error at %0t: response seen without a strobe", $time);
    errors++;
  end
  check_fault(fault_valid_o, fault_addr_o, exp_fault_valid, exp_fault_addr);
  // Capture state after the coming edge, clear wins
  if (clr) begin
    exp_fault_valid = 1'b0;
  end else if (pend_valid && pend_resp.err && !exp_fault_valid) begin
    exp_fault_valid = 1'b1;
    exp_fault_addr  = pend_addr;
  end
  trans_valid_i = valid;
  trans_i       = t;
  fault_clr_i   = clr;
  pend_valid    = valid;
  pend_resp     = predict_resp(t);
  pend_addr     = t.addr;
  @(posedge clk);
  #1;
endtask

task automatic idle(input int n);
  repeat (n) run_cycle(1'b0, '0, 1'b0);
endtask

// Table write, seen by strobes after the write edge
task automatic write_region(input logic [PMA_IDX_W-1:0] idx, input pma_cfg_t c);
  cfg_we_i   = 1'b1;
  cfg_idx_i  = idx;
  cfg_data_i = c;
  run_cycle(1'b0, '0, 1'b0);
  cfg_we_i       = 1'b0;
  model_tbl[idx] = c;
endtask

task automatic begin_test();
  test_start = errors;
endtask

task automatic end_test(input string name);
  if (errors == test_start) begin
    tests_passed++;
    $display("%s: passed", name);
  end else begin
    tests_failed++;
    $display("%s: failed with %0d errors", name, errors - test_start);
  end
endtask

`endif

/* test/pma_tb.sv */
/*
 * PMA unit testbench: clock, reset, watchdog, DUT
 * and the directed test sequence
 */

`timescale 1ns/100ps
`default_nettype none

module pma_tb import pma_pkg::*; ();

  localparam logic [31:0] SEED = 32'h9ae5_30cf;

  // Cycle budget per test, the watchdog uses the sum
  localparam int CYC_RESET   = 4;
  localparam int CYC_DEFAULT = 16;
  localparam int CYC_RANDOM  = 50;
  localparam int CYC_OVERLAP = 14;
  localparam int CYC_BUFFER  = 8;
  localparam int CYC_DEBUG   = 12;
  localparam int CYC_FAULT   = 24;
  localparam int TOTAL_CYC   = CYC_RESET + CYC_DEFAULT + CYC_RANDOM + CYC_OVERLAP +
                               CYC_BUFFER + CYC_DEBUG + CYC_FAULT;
  localparam int WATCHDOG_NS = TOTAL_CYC * 4 + 200;

  logic                 clk;
  logic                 reset_i;
  logic                 cfg_we_i;
  logic [PMA_IDX_W-1:0] cfg_idx_i;
  pma_cfg_t             cfg_data_i;
  logic                 fault_clr_i;
  logic                 trans_valid_i;
  pma_trans_t           trans_i;
  logic                 resp_valid_o;
  pma_resp_t            resp_o;
  logic                 fault_valid_o;
  logic [31:0]          fault_addr_o;

  int errors;
  int test_start;
  int tests_passed;
  int tests_failed;

  `include "pma_tb_tasks.svh"

  pma_unit_top u_dut (
    .clk           (clk),
    .reset_i       (reset_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_idx_i     (cfg_idx_i),
    .cfg_data_i    (cfg_data_i),
    .fault_clr_i   (fault_clr_i),
    .trans_valid_i (trans_valid_i),
    .trans_i       (trans_i),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o),
    .fault_valid_o (fault_valid_o),
    .fault_addr_o  (fault_addr_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  // Empty table, every kind with all qualifier mixes
  task automatic defaults_after_reset();
    begin_test();
    for (int k = 0; k < 3; k++) begin
      for (int m = 0; m < 4; m++) begin
        run_cycle(1'b1, make_trans(32'h4000_0000 | ($urandom & 32'h0fff_fffc),
                                   access_kind_e'(k), m[0], m[1], 1'b0), 1'b0);
      end
    end
    idle(2);
    end_test("defaults after reset");
  endtask

  // Random table, then back-to-back strobes around it
  task automatic random_regions();
    logic [31:0] lo;
    begin_test();
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      lo = 32'h1000 + ($urandom % 256);
      write_region(PMA_IDX_W'(i), make_cfg(lo, lo + 1 + ($urandom % 64), 1'($urandom),
                                          1'($urandom), 1'($urandom), 1'($urandom)));
    end
    for (int n = 0; n < 40; n++) begin
      run_cycle(1'b1, make_trans(((32'h1000 + ($urandom % 384)) << 2) | ($urandom & 32'h3),
                                 access_kind_e'($urandom % 3), 1'($urandom),
                                 1'($urandom), 1'($urandom)), 1'b0);
    end
    idle(2);
    end_test("random regions");
  endtask

  // Region 2 over region 1, high bound is exclusive
  task automatic overlap_priority();
    begin_test();
    write_region(2'd1, make_cfg(32'h2000, 32'h2100, 1'b1, 1'b1, 1'b0, 1'b1));
    write_region(2'd2, make_cfg(32'h2080, 32'h2200, 1'b0, 1'b0, 1'b1, 1'b0));
    run_cycle(1'b1, make_trans(32'h2090 << 2, ACC_STORE, 1'b0, 1'b0, 1'b0), 1'b0);
    run_cycle(1'b1, make_trans(32'h2010 << 2, ACC_LOAD, 1'b0, 1'b0, 1'b0), 1'b0);
    run_cycle(1'b1, make_trans(32'h2090 << 2, ACC_FETCH, 1'b0, 1'b0, 1'b0), 1'b0);
    run_cycle(1'b1, make_trans(32'h2100 << 2, ACC_STORE, 1'b0, 1'b0, 1'b0), 1'b0);
    run_cycle(1'b1, make_trans(32'h21ff << 2, ACC_STORE, 1'b0, 1'b1, 1'b0), 1'b0);
    run_cycle(1'b1, make_trans(32'h2200 << 2, ACC_STORE, 1'b0, 1'b0, 1'b0), 1'b0);
    run_cycle(1'b1, make_trans(32'h2200 << 2, ACC_FETCH, 1'b0, 1'b0, 1'b0), 1'b0);
    idle(2);
    end_test("overlapping regions");
  endtask

  task automatic bufferable_rule();
    begin_test();
    write_region(2'd3, make_cfg(32'h3000, 32'h3010, 1'b1, 1'b1, 1'b1, 1'b1));
    run_cycle(1'b1, make_trans(32'h3004 << 2, ACC_FETCH, 1'b0, 1'b0, 1'b0), 1'b0);
    run_cycle(1'b1, make_trans(32'h3004 << 2, ACC_LOAD, 1'b0, 1'b0, 1'b0), 1'b0);
    run_cycle(1'b1, make_trans(32'h3004 << 2, ACC_STORE, 1'b0, 1'b0, 1'b0), 1'b0);
    idle(2);
    end_test("bufferable rule");
  endtask

  // I/O region across the debug window, both modes
  task automatic debug_override();
    begin_test();
    write_region(2'd0, make_cfg((DM_REGION_START >> 2) - 32'h100,
                                (DM_REGION_END >> 2) + 32'h100, 1'b0, 1'b1, 1'b1, 1'b1));
    for (int d = 1; d >= 0; d--) begin
      run_cycle(1'b1, make_trans(DM_REGION_START + 32'h40, ACC_FETCH, 1'b0, 1'b0, d[0]), 1'b0);
      run_cycle(1'b1, make_trans(DM_REGION_START + 32'h40, ACC_LOAD, 1'b0, 1'b0, d[0]), 1'b0);
      run_cycle(1'b1, make_trans(DM_REGION_START + 32'h40, ACC_STORE, 1'b0, 1'b0, d[0]), 1'b0);
    end
    run_cycle(1'b1, make_trans(DM_REGION_END, ACC_STORE, 1'b0, 1'b1, 1'b1), 1'b0);
    run_cycle(1'b1, make_trans(DM_REGION_START - 32'h4, ACC_FETCH, 1'b0, 1'b0, 1'b1), 1'b0);
    idle(2);
    end_test("debug override");
  endtask

  task automatic fault_capture();
    begin_test();
    // Drop captures left by earlier tests
    run_cycle(1'b0, '0, 1'b1);
    run_cycle(1'b1, make_trans(32'h8000_0100, ACC_FETCH, 1'b0, 1'b0, 1'b0), 1'b0);
    run_cycle(1'b1, make_trans(32'h8000_0200, ACC_LOAD, 1'b1, 1'b0, 1'b0), 1'b0);
    run_cycle(1'b1, make_trans(32'h8000_0300, ACC_STORE, 1'b0, 1'b1, 1'b0), 1'b0);
    idle(2);
    check_fault(fault_valid_o, fault_addr_o, 1'b1, 32'h8000_0100);
    run_cycle(1'b0, '0, 1'b1);
    run_cycle(1'b1, make_trans(32'h8000_0400, ACC_FETCH, 1'b0, 1'b0, 1'b0), 1'b0);
    idle(2);
    check_fault(fault_valid_o, fault_addr_o, 1'b1, 32'h8000_0400);
    // Clear meets the next fault in one cycle
    run_cycle(1'b0, '0, 1'b1);
    run_cycle(1'b1, make_trans(32'h8000_0500, ACC_FETCH, 1'b0, 1'b0, 1'b0), 1'b0);
    run_cycle(1'b0, '0, 1'b1);
    idle(2);
    end_test("fault capture");
  endtask

  initial begin
    void'($urandom(SEED));
    errors          = 0;
    test_start      = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    reset_i         = 1'b1;
    cfg_we_i        = 1'b0;
    cfg_idx_i       = '0;
    cfg_data_i      = '0;
    fault_clr_i     = 1'b0;
    trans_valid_i   = 1'b0;
    trans_i         = '0;
    pend_valid      = 1'b0;
    pend_resp       = '0;
    pend_addr       = '0;
    exp_fault_valid = 1'b0;
    exp_fault_addr  = '0;
    for (int i = 0; i < PMA_NUM_REGIONS; i++) begin
      model_tbl[i] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    reset_i = 1'b0;
    defaults_after_reset();
    random_regions();
    overlap_priority();
    bufferable_rule();
    debug_override();
    fault_capture();
    $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (errors == 0 && tests_failed == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src/pma_unit_top.sv */
/*
 * PMA unit top: configuration block and checker
 */

`timescale 1ns/100ps
`default_nettype none

module pma_unit_top import pma_pkg::*; (
  input  wire                  clk,
  input  wire                  reset_i,

  // Table write port
  input  wire                  cfg_we_i,
  input  wire [PMA_IDX_W-1:0]  cfg_idx_i,
  input  wire pma_cfg_t        cfg_data_i,
  input  wire                  fault_clr_i,

  // Transaction strobe
  input  wire                  trans_valid_i,
  input  wire pma_trans_t      trans_i,

  // Response and captured fault
  output logic                 resp_valid_o,
  output pma_resp_t            resp_o,
  output logic                 fault_valid_o,
  output logic [31:0]          fault_addr_o
);

  // Registered table, config block to checker
  pma_cfg_t [PMA_NUM_REGIONS-1:0] region_tbl;
  // Fault report, checker to config block
  pma_fault_t                     fault;

  //////////////////////////////////////////////////////////////
  // Configuration block
  //////////////////////////////////////////////////////////////

  pma_region_regs u_regs (
    .clk           (clk),
    .reset_i       (reset_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_idx_i     (cfg_idx_i),
    .cfg_data_i    (cfg_data_i),
    .fault_clr_i   (fault_clr_i),
    .fault_i       (fault),
    .region_tbl_o  (region_tbl),
    .fault_valid_o (fault_valid_o),
    .fault_addr_o  (fault_addr_o)
  );

  //////////////////////////////////////////////////////////////
  // Checker
  //////////////////////////////////////////////////////////////

  pma_checker u_checker (
    .clk           (clk),
    .reset_i       (reset_i),
    .trans_valid_i (trans_valid_i),
    .trans_i       (trans_i),
    .region_tbl_i  (region_tbl),
    .resp_valid_o  (resp_valid_o),
    .resp_o        (resp_o),
    .fault_o       (fault)
  );

endmodule

`default_nettype wire

/* src/pma_checker.sv */
/*
 * PMA checker: region match, debug window override,
 * error and attribute rules, one-cycle response register
 */

`timescale 1ns/100ps
`default_nettype none

module pma_checker import pma_pkg::*; (
  input  wire                                  clk,
  input  wire                                  reset_i,

  // Transaction strobe
  input  wire                                  trans_valid_i,
  input  wire pma_trans_t                      trans_i,

  // Region table from the configuration block
  input  wire pma_cfg_t [PMA_NUM_REGIONS-1:0]  region_tbl_i,

  // Response, one cycle after the strobe
  output logic                                 resp_valid_o,
  output pma_resp_t                            resp_o,

  // Fault report, same cycle as an erroring response
  output pma_fault_t                           fault_o
);

  //////////////////////////////////////////////////////////////
  // Region selection
  //////////////////////////////////////////////////////////////

  logic [31:0] word_addr;
  pma_cfg_t    region_cfg;
  pma_cfg_t    sel_cfg;
  logic        dbg_hit;

  // Table bounds are word addresses
  assign word_addr = {2'b00, trans_i.addr[31:2]};

  // Highest index searched first, first hit is kept
  // Default attributes when nothing matches
  always_comb begin : region_select
    logic hit;
    hit        = 1'b0;
    region_cfg = PMA_R_DEFAULT;
    for (int i = PMA_NUM_REGIONS - 1; i >= 0; i--) begin
      if (!hit &&
          (word_addr >= region_tbl_i[i].word_addr_low) &&
          (word_addr <  region_tbl_i[i].word_addr_high)) begin
        region_cfg = region_tbl_i[i];
        hit        = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////
  // Debug override
  //////////////////////////////////////////////////////////////

  // Window test on the byte address, end exclusive
  assign dbg_hit = trans_i.debug_mode &&
                   (trans_i.addr >= DM_REGION_START) &&
                   (trans_i.addr <  DM_REGION_END);

  // Debug attributes replace whatever the table gave
  assign sel_cfg = dbg_hit ? PMA_DBG : region_cfg;

  //////////////////////////////////////////////////////////////
  // Error and attribute rules
  //////////////////////////////////////////////////////////////

  pma_resp_t resp_d;
  logic      is_fetch;
  logic      is_load;

  assign is_fetch = (trans_i.kind == ACC_FETCH);
  assign is_load  = (trans_i.kind == ACC_LOAD);

  always_comb begin
    resp_d = '0;

    // Fetch, misaligned and push/pop all need main memory
    if (!sel_cfg.main) begin
      if (is_fetch || trans_i.misaligned || trans_i.pushpop) begin
        resp_d.err = 1'b1;
      end
    end

    // Integrity and cacheable straight from the entry
    resp_d.integrity = sel_cfg.integrity;
    resp_d.cacheable = sel_cfg.cacheable;

    // Fetches and loads never bufferable
    resp_d.bufferable = sel_cfg.bufferable && !is_fetch && !is_load;
  end

  //////////////////////////////////////////////////////////////
  // Response register
  //////////////////////////////////////////////////////////////

  logic        resp_valid_q;
  pma_resp_t   resp_q;
  logic        fault_valid_q;
  logic [31:0] fault_addr_q;

  // Control bits, cleared by reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      resp_valid_q  <= 1'b0;
      fault_valid_q <= 1'b0;
    end else begin
      resp_valid_q  <= trans_valid_i;
      fault_valid_q <= trans_valid_i && resp_d.err;
    end
  end

  // Payload, loaded with each strobe
  always_ff @(posedge clk) begin
    if (trans_valid_i) begin
      resp_q       <= resp_d;
      fault_addr_q <= trans_i.addr;
    end
  end

  assign resp_valid_o  = resp_valid_q;
  assign resp_o        = resp_q;
  assign fault_o.valid = fault_valid_q;
  assign fault_o.addr  = fault_addr_q;

endmodule

`default_nettype wire

/* src/pma_region_regs.sv */
/*
 * Region table registers with single-entry write port,
 * and the sticky first-fault address capture
 */

`timescale 1ns/100ps
`default_nettype none

module pma_region_regs import pma_pkg::*; (
  input  wire                                  clk,
  input  wire                                  reset_i,

  // Table write port
  input  wire                                  cfg_we_i,
  input  wire [PMA_IDX_W-1:0]                  cfg_idx_i,
  input  wire pma_cfg_t                        cfg_data_i,

  // Fault capture
  input  wire                                  fault_clr_i,
  input  wire pma_fault_t                      fault_i,

  // Table toward the checker
  output pma_cfg_t [PMA_NUM_REGIONS-1:0]       region_tbl_o,

  // Captured fault toward software
  output logic                                 fault_valid_o,
  output logic [31:0]                          fault_addr_o
);

  //////////////////////////////////////////////////////////////
  // Region table
  //////////////////////////////////////////////////////////////

  // Whole table, one packed entry per region
  pma_cfg_t [PMA_NUM_REGIONS-1:0] region_tbl_q;

  // Reset leaves every entry as a zero range
  // Low equal to high, so no entry can match
  // One entry written per strobe, others keep their value
  always_ff @(posedge clk) begin
    if (reset_i) begin
      region_tbl_q <= '0;
    end else if (cfg_we_i) begin
      region_tbl_q[cfg_idx_i] <= cfg_data_i;
    end
  end

  // Checker sees the registered table
  // A write at edge k applies to strobes from cycle k+1 on
  assign region_tbl_o = region_tbl_q;

  //////////////////////////////////////////////////////////////
  // First-fault capture
  //////////////////////////////////////////////////////////////

  logic        fault_valid_q;
  logic [31:0] fault_addr_q;
  logic        fault_load;

  // Load only while nothing is held
  // A clear in the same cycle takes priority
  assign fault_load = fault_i.valid && !fault_valid_q && !fault_clr_i;

  // Sticky valid flag
  always_ff @(posedge clk) begin
    if (reset_i) begin
      fault_valid_q <= 1'b0;
    end else if (fault_clr_i) begin
      fault_valid_q <= 1'b0;
    end else if (fault_load) begin
      fault_valid_q <= 1'b1;
    end
  end

  // Captured address
  // Zero from reset until the first fault
  // Left as is on a clear, only the flag is dropped
  always_ff @(posedge clk) begin
    if (reset_i) begin
      fault_addr_q <= 32'h0;
    end else if (fault_load) begin
      fault_addr_q <= fault_i.addr;
    end
  end

  // Fault outputs, one cycle after the faulting response
  assign fault_valid_o = fault_valid_q;
  assign fault_addr_o  = fault_addr_q;

endmodule

`default_nettype wire

/* src/pma_pkg.sv */
/*
 * Shared package of the PMA unit: region count, debug window bounds,
 * default and debug attributes, transaction, response and fault types
 */

`default_nettype none

package pma_pkg;

  //////////////////////////////////////////////////////////////
  // Sizes and address bounds
  //////////////////////////////////////////////////////////////

  // Number of entries in the region table
  localparam int unsigned PMA_NUM_REGIONS = 4;
  // Width of a region index
  localparam int unsigned PMA_IDX_W = $clog2(PMA_NUM_REGIONS);

  // Debug module window, byte addresses, end is exclusive
  localparam logic [31:0] DM_REGION_START = 32'h1A11_0000;
  localparam logic [31:0] DM_REGION_END   = 32'h1A11_1000;

  //////////////////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////////////////

  // One region entry, bounds are word addresses
  typedef struct packed {
    logic [31:0] word_addr_low;   // Inclusive
    logic [31:0] word_addr_high;  // Exclusive
    logic        main;
    logic        bufferable;
    logic        cacheable;
    logic        integrity;
  } pma_cfg_t;

  // Access kind of a transaction
  typedef enum logic [1:0] {
    ACC_FETCH = 2'd0,
    ACC_LOAD  = 2'd1,
    ACC_STORE = 2'd2
  } access_kind_e;

  // Transaction presented to the checker
  typedef struct packed {
    logic [31:0]  addr;        // Byte address
    access_kind_e kind;
    logic         misaligned;  // Part of a misaligned access
    logic         pushpop;     // Part of a push or pop sequence
    logic         debug_mode;
  } pma_trans_t;

  // Response of the checker
  typedef struct packed {
    logic err;
    logic integrity;
    logic bufferable;
    logic cacheable;
  } pma_resp_t;

  // Fault report toward the capture register
  typedef struct packed {
    logic        valid;
    logic [31:0] addr;
  } pma_fault_t;

  //////////////////////////////////////////////////////////////
  // Fixed attribute sets
  //////////////////////////////////////////////////////////////

  // No region hit, treat as I/O
  localparam pma_cfg_t PMA_R_DEFAULT = '0;

  // Debug module window in debug mode, bounds not used
  localparam pma_cfg_t PMA_DBG = '{word_addr_low  : 32'h0,
                                   word_addr_high : 32'h0,
                                   main           : 1'b1,
                                   bufferable     : 1'b0,
                                   cacheable      : 1'b0,
                                   integrity      : 1'b0};

endpackage

`default_nettype wire
